// ==== motor_pkg.sv ====
`default_nettype none

package motor_pkg;

	localparam int STEP_W = 16;
	localparam int SPEED_W = 16;
	localparam int ADDR_W = 9;
	localparam int MS_W = 3;
	localparam int TABLE_DEPTH = 2 ** ADDR_W;

	// clk cycles per step tick
	localparam int TICK_DIV = 4;
	localparam int TICK_W = $clog2(TICK_DIV);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_DIV - 1);

	// ticks before a reversed move starts
	localparam int REVERSE_DELAY = 4;
	localparam int REV_W = $clog2(REVERSE_DELAY);
	localparam logic [REV_W-1:0] REV_LAST = REV_W'(REVERSE_DELAY - 2);

	localparam logic [STEP_W-1:0] INIT_POSITION = STEP_W'(1);

	// linear ramp, address zero is the slowest entry
	localparam int SPEED_TOP = 40;
	localparam int SPEED_SLOPE = 2;
	localparam int TABLE_LAT = 2;

	typedef enum logic [1:0] {
		ST_IDLE    = 2'b00,
		ST_PREPARE = 2'b10,
		ST_RUNNING = 2'b11
	} motor_state_e;

	typedef struct packed {
		logic [SPEED_W-1:0] speed;
		logic [STEP_W-1:0]  steps;
		logic               dir;
		logic [MS_W-1:0]    ms;
	} motor_cmd_t;

	typedef struct packed {
		logic               busy;
		logic               zpsign;
		logic               tpsign;
		logic [SPEED_W-1:0] rt_speed;
		logic [STEP_W-1:0]  position;
	} motor_status_t;

	// half-period for a table address, floored at zero
	function automatic logic [SPEED_W-1:0] ramp_speed(input int addr);
		int v;
		v = SPEED_TOP - SPEED_SLOPE * addr;
		if (v < 0) begin
			v = 0;
		end
		return SPEED_W'(v);
	endfunction

endpackage

`default_nettype wire

// ==== step_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_tick_gen (
	input  wire  clk,
	input  wire  resetn,
	output logic o_tick
);

	logic [motor_pkg::TICK_W-1:0] tick_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_cnt <= '0;
		end else if (tick_cnt == motor_pkg::TICK_LAST) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// one clk wide, on the last count
	assign o_tick = (tick_cnt == motor_pkg::TICK_LAST);

endmodule

`default_nettype wire

// ==== speed_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_table (
	input  wire                           clk,
	input  wire                           i_a_en,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_a_addr,
	output logic [motor_pkg::SPEED_W-1:0] o_a_data,
	input  wire                           i_b_en,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_b_addr,
	output logic [motor_pkg::SPEED_W-1:0] o_b_data
);

	logic [motor_pkg::SPEED_W-1:0] rom [motor_pkg::TABLE_DEPTH];
	logic [1:0]                    rd_en;
	logic [1:0][motor_pkg::ADDR_W-1:0] rd_addr;
	logic [motor_pkg::SPEED_W-1:0] rd_pipe [2][motor_pkg::TABLE_LAT];

	initial begin
		for (int i = 0; i < motor_pkg::TABLE_DEPTH; i++) begin
			rom[i] = motor_pkg::ramp_speed(i);
		end
	end

	// port a for acceleration, port b for deceleration
	assign rd_en = {i_b_en, i_a_en};
	assign rd_addr = {i_b_addr, i_a_addr};

	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (rd_en[p]) begin
				rd_pipe[p][0] <= rom[rd_addr[p]];
			end
			// output register stages
			for (int s = 1; s < motor_pkg::TABLE_LAT; s++) begin
				rd_pipe[p][s] <= rd_pipe[p][s-1];
			end
		end
	end

	assign o_a_data = rd_pipe[0][motor_pkg::TABLE_LAT-1];
	assign o_b_data = rd_pipe[1][motor_pkg::TABLE_LAT-1];

endmodule

`default_nettype wire

// ==== motor_cmd_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_cmd_select (
	input  wire                   clk,
	input  wire                   resetn,
	input  wire                   i_tick,
	input  wire                   i_busy,
	input  wire                   i_sel,
	input  wire motor_pkg::motor_cmd_t i_pri_cmd,
	input  wire motor_pkg::motor_cmd_t i_ext_cmd,
	input  wire                   i_pri_start,
	input  wire                   i_pri_stop,
	input  wire                   i_ext_start,
	input  wire                   i_ext_stop,
	output motor_pkg::motor_cmd_t o_cmd,
	output logic                  o_start_pend,
	output logic                  o_stop_pend
);

	motor_pkg::motor_cmd_t live_cmd;
	logic                  live_start;
	logic                  live_stop;
	logic                  take_start;

	assign live_cmd = i_sel ? i_ext_cmd : i_pri_cmd;
	assign live_start = i_sel ? i_ext_start : i_pri_start;
	assign live_stop = i_sel ? i_ext_stop : i_pri_stop;
	assign take_start = !o_start_pend && !i_busy && live_start;

	// held until the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_start_pend <= 1'b0;
		end else if (o_start_pend) begin
			if (i_tick) begin
				o_start_pend <= 1'b0;
			end
		end else if (take_start) begin
			o_start_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take_start) begin
			o_cmd <= live_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_stop_pend <= 1'b0;
		end else if (o_stop_pend) begin
			if (i_tick) begin
				o_stop_pend <= 1'b0;
			end
		end else if (i_busy && live_stop) begin
			o_stop_pend <= 1'b1;
		end
	end

	// the core leaves idle on the same tick that consumes the start
	a_start_not_busy: assert property (
		@(posedge clk) disable iff (!resetn) !(o_start_pend && i_busy)
	);

endmodule

`default_nettype wire

// ==== step_motor_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_motor_core (
	input  wire                           clk,
	input  wire                           resetn,
	input  wire                           i_tick,
	input  wire motor_pkg::motor_cmd_t    i_cmd,
	input  wire                           i_start_pend,
	input  wire                           i_stop_pend,
	input  wire                           i_limit_stop,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_acce_max,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_deac_max,
	output logic                          o_a_en,
	output logic [motor_pkg::ADDR_W-1:0]  o_a_addr,
	input  wire  [motor_pkg::SPEED_W-1:0] i_a_data,
	output logic                          o_b_en,
	output logic [motor_pkg::ADDR_W-1:0]  o_b_addr,
	input  wire  [motor_pkg::SPEED_W-1:0] i_b_data,
	output logic                          o_busy,
	output logic [motor_pkg::SPEED_W-1:0] o_rt_speed,
	output logic                          o_drive,
	output logic                          o_dir,
	output logic [motor_pkg::MS_W-1:0]    o_ms
);

	motor_pkg::motor_state_e          state;
	logic [motor_pkg::REV_W-1:0]      rev_cnt;
	logic [motor_pkg::STEP_W-1:0]     step_cnt;
	logic [motor_pkg::STEP_W-1:0]     step_remain;
	logic [motor_pkg::SPEED_W-1:0]    speed_cnt;
	logic [motor_pkg::SPEED_W-1:0]    speed_cur;
	logic [motor_pkg::SPEED_W-1:0]    speed_max;
	logic [motor_pkg::SPEED_W-1:0]    speed_var;
	logic [motor_pkg::SPEED_W-1:0]    start_speed;
	logic                             rd_en;
	logic [motor_pkg::TABLE_LAT+2:0]  rd_pipe;
	logic                             acce_ing;
	logic                             deac_ing;
	logic                             running;
	logic                             should_start;
	logic                             phase_end;
	logic                             finish;
	logic                             leave;
	logic                             go_rise;

	assign o_busy = state[1];
	assign running = (state == motor_pkg::ST_RUNNING);
	assign should_start = i_tick && i_start_pend && (state == motor_pkg::ST_IDLE);
	assign phase_end = running && (speed_cnt == '0);
	assign finish = phase_end && !o_drive && (step_remain == '0);
	assign leave = i_stop_pend || i_limit_stop || finish;
	assign go_rise = phase_end && !o_drive && (step_remain != '0) && !leave;

	// first step runs at table entry zero
	assign start_speed = (motor_pkg::ramp_speed(0) > i_cmd.speed) ?
		motor_pkg::ramp_speed(0) : i_cmd.speed;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= motor_pkg::ST_IDLE;
		end else if (i_tick) begin
			case (state)
			motor_pkg::ST_IDLE: begin
				if (i_start_pend) begin
					state <= (i_cmd.dir == o_dir) ? motor_pkg::ST_RUNNING :
						motor_pkg::ST_PREPARE;
				end
			end
			motor_pkg::ST_PREPARE: begin
				if (i_stop_pend) begin
					state <= motor_pkg::ST_IDLE;
				end else if (rev_cnt == motor_pkg::REV_LAST) begin
					state <= motor_pkg::ST_RUNNING;
				end
			end
			motor_pkg::ST_RUNNING: begin
				if (leave) begin
					state <= motor_pkg::ST_IDLE;
				end
			end
			default: state <= motor_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rev_cnt <= '0;
		end else if (i_tick) begin
			rev_cnt <= (state == motor_pkg::ST_PREPARE) ? rev_cnt + 1'b1 : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_dir <= 1'b0;
		end else if (should_start) begin
			o_dir <= i_cmd.dir;
		end
	end

	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_max <= i_cmd.speed;
			o_ms <= i_cmd.ms;
		end
	end

	// steps done and steps left, both move on a drive rise
	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt <= '0;
			step_remain <= '0;
		end else if (should_start) begin
			step_cnt <= '0;
			step_remain <= i_cmd.steps;
		end else if (i_tick && go_rise) begin
			step_cnt <= step_cnt + 1'b1;
			step_remain <= step_remain - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
		end else if (i_tick) begin
			if (!running) begin
				speed_cnt <= '0;
			end else if (speed_cnt == '0) begin
				speed_cnt <= speed_cur;
			end else begin
				speed_cnt <= speed_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_drive <= 1'b0;
		end else if (i_tick) begin
			if (!running || leave) begin
				o_drive <= 1'b0;
			end else if (go_rise) begin
				o_drive <= 1'b1;
			end else if (phase_end) begin
				o_drive <= 1'b0;
			end
		end
	end

	// table read pipeline, one read per drive rise
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en <= 1'b0;
			rd_pipe <= '0;
		end else begin
			rd_en <= i_tick && go_rise;
			rd_pipe <= {rd_pipe[motor_pkg::TABLE_LAT+1:0], rd_en};
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			acce_ing <= (step_cnt[motor_pkg::STEP_W-1:motor_pkg::ADDR_W] == '0) &&
				(step_cnt[motor_pkg::ADDR_W-1:0] < i_acce_max);
			deac_ing <= (step_remain[motor_pkg::STEP_W-1:motor_pkg::ADDR_W] == '0) &&
				(step_remain[motor_pkg::ADDR_W-1:0] < i_deac_max);
		end
		if (rd_pipe[0]) begin
			o_a_addr <= acce_ing ? step_cnt[motor_pkg::ADDR_W-1:0] : i_acce_max;
			o_b_addr <= deac_ing ? step_remain[motor_pkg::ADDR_W-1:0] : i_deac_max;
		end
		// slowest of the two ramps
		if (rd_pipe[motor_pkg::TABLE_LAT+1]) begin
			speed_var <= (i_a_data > i_b_data) ? i_a_data : i_b_data;
		end
	end

	assign o_a_en = rd_pipe[1];
	assign o_b_en = rd_pipe[1];

	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_cur <= start_speed;
		end else if (rd_pipe[motor_pkg::TABLE_LAT+2]) begin
			speed_cur <= (speed_var > speed_max) ? speed_var : speed_max;
		end
	end

	assign o_rt_speed = speed_cur;

	a_drive_in_running: assert property (
		@(posedge clk) disable iff (!resetn) o_drive |-> running
	);

endmodule

`default_nettype wire

// ==== position_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module position_tracker (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          i_zpd,
	input  wire  [motor_pkg::STEP_W-1:0] i_stroke,
	input  wire                          i_drive,
	input  wire                          i_dir,
	input  wire                          i_busy,
	output logic                         o_zpsign,
	output logic                         o_tpsign,
	output logic [motor_pkg::STEP_W-1:0] o_position,
	output logic                         o_limit_stop
);

	logic                         drive_d;
	logic                         fall;
	logic                         fwd;
	logic [motor_pkg::STEP_W-1:0] pos_next;

	assign fall = drive_d && !i_drive;
	assign fwd = !i_dir;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			drive_d <= 1'b0;
		end else begin
			drive_d <= i_drive;
		end
	end

	// set any time, released only when leaving zero forward
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_zpsign <= 1'b0;
		end else if (i_zpd) begin
			o_zpsign <= 1'b1;
		end else if (i_busy && fwd) begin
			o_zpsign <= 1'b0;
		end
	end

	// saturating step between zero and stroke
	always_comb begin
		pos_next = o_position;
		if (fwd) begin
			if (o_position < i_stroke) begin
				pos_next = o_position + 1'b1;
			end
		end else if (o_position > motor_pkg::INIT_POSITION) begin
			pos_next = o_position - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_position <= motor_pkg::INIT_POSITION;
		end else if (o_zpsign) begin
			o_position <= motor_pkg::INIT_POSITION;
		end else if (fall) begin
			o_position <= pos_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_tpsign <= 1'b0;
		end else if (fall) begin
			o_tpsign <= !o_zpsign && (pos_next == i_stroke);
		end
	end

	assign o_limit_stop = (o_tpsign && fwd) || (o_zpsign && !fwd);

endmodule

`default_nettype wire

// ==== stepper_axis.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_axis (
	input  wire                           clk,
	input  wire                           resetn,
	input  wire                           i_sel,
	input  wire motor_pkg::motor_cmd_t    i_pri_cmd,
	input  wire                           i_pri_start,
	input  wire                           i_pri_stop,
	input  wire motor_pkg::motor_cmd_t    i_ext_cmd,
	input  wire                           i_ext_start,
	input  wire                           i_ext_stop,
	input  wire                           i_zpd,
	input  wire  [motor_pkg::STEP_W-1:0]  i_stroke,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_acce_max,
	input  wire  [motor_pkg::ADDR_W-1:0]  i_deac_max,
	output logic                          o_drive,
	output logic                          o_dir,
	output logic [motor_pkg::MS_W-1:0]    o_ms,
	output motor_pkg::motor_status_t      o_status
);

	motor_pkg::motor_cmd_t         cmd;
	logic                          tick;
	logic                          start_pend;
	logic                          stop_pend;
	logic                          busy;
	logic                          limit_stop;
	logic                          a_en;
	logic                          b_en;
	logic [motor_pkg::ADDR_W-1:0]  a_addr;
	logic [motor_pkg::ADDR_W-1:0]  b_addr;
	logic [motor_pkg::SPEED_W-1:0] a_data;
	logic [motor_pkg::SPEED_W-1:0] b_data;
	logic [motor_pkg::SPEED_W-1:0] rt_speed;
	logic [motor_pkg::STEP_W-1:0]  position;
	logic                          zpsign;
	logic                          tpsign;

	step_tick_gen i_step_tick_gen (
		.clk    (clk),
		.resetn (resetn),
		.o_tick (tick)
	);

	speed_table i_speed_table (
		.clk      (clk),
		.i_a_en   (a_en),
		.i_a_addr (a_addr),
		.o_a_data (a_data),
		.i_b_en   (b_en),
		.i_b_addr (b_addr),
		.o_b_data (b_data)
	);

	motor_cmd_select i_motor_cmd_select (
		.clk          (clk),
		.resetn       (resetn),
		.i_tick       (tick),
		.i_busy       (busy),
		.i_sel        (i_sel),
		.i_pri_cmd    (i_pri_cmd),
		.i_ext_cmd    (i_ext_cmd),
		.i_pri_start  (i_pri_start),
		.i_pri_stop   (i_pri_stop),
		.i_ext_start  (i_ext_start),
		.i_ext_stop   (i_ext_stop),
		.o_cmd        (cmd),
		.o_start_pend (start_pend),
		.o_stop_pend  (stop_pend)
	);

	step_motor_core i_step_motor_core (
		.clk          (clk),
		.resetn       (resetn),
		.i_tick       (tick),
		.i_cmd        (cmd),
		.i_start_pend (start_pend),
		.i_stop_pend  (stop_pend),
		.i_limit_stop (limit_stop),
		.i_acce_max   (i_acce_max),
		.i_deac_max   (i_deac_max),
		.o_a_en       (a_en),
		.o_a_addr     (a_addr),
		.i_a_data     (a_data),
		.o_b_en       (b_en),
		.o_b_addr     (b_addr),
		.i_b_data     (b_data),
		.o_busy       (busy),
		.o_rt_speed   (rt_speed),
		.o_drive      (o_drive),
		.o_dir        (o_dir),
		.o_ms         (o_ms)
	);

	position_tracker i_position_tracker (
		.clk          (clk),
		.resetn       (resetn),
		.i_zpd        (i_zpd),
		.i_stroke     (i_stroke),
		.i_drive      (o_drive),
		.i_dir        (o_dir),
		.i_busy       (busy),
		.o_zpsign     (zpsign),
		.o_tpsign     (tpsign),
		.o_position   (position),
		.o_limit_stop (limit_stop)
	);

	assign o_status = '{
		busy:     busy,
		zpsign:   zpsign,
		tpsign:   tpsign,
		rt_speed: rt_speed,
		position: position
	};

endmodule

`default_nettype wire

// ==== tb_stepper_axis.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stepper_axis;

	typedef struct packed {
		bit sel;
		bit use_ext;
		bit dir;
		int speed;
		int steps;
		int stroke;
		int stop_at;
		int zpd_at;
		int exp_steps;
		int exp_pos;
		bit exp_zp;
		bit exp_tp;
	} move_t;

	logic                           clk = 1'b0;
	logic                           resetn;
	logic                           i_sel;
	motor_pkg::motor_cmd_t          i_pri_cmd;
	logic                           i_pri_start;
	logic                           i_pri_stop;
	motor_pkg::motor_cmd_t          i_ext_cmd;
	logic                           i_ext_start;
	logic                           i_ext_stop;
	logic                           i_zpd;
	logic [motor_pkg::STEP_W-1:0]   i_stroke;
	logic [motor_pkg::ADDR_W-1:0]   i_acce_max;
	logic [motor_pkg::ADDR_W-1:0]   i_deac_max;
	logic                           o_drive;
	logic                           o_dir;
	logic [motor_pkg::MS_W-1:0]     o_ms;
	motor_pkg::motor_status_t       o_status;

	move_t       rows [7];
	int          acce_cap = 10;
	int          deac_cap = 10;
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	int          limit = 0;
	int          cycles = 0;
	int          rises = 0;
	int          settle = 0;
	int          pos_model = 1;
	logic        drive_q = 1'b0;
	int          speed_log [$];
	logic [15:0] lfsr = 16'd32476;

	stepper_axis i_stepper_axis (
		.clk         (clk),
		.resetn      (resetn),
		.i_sel       (i_sel),
		.i_pri_cmd   (i_pri_cmd),
		.i_pri_start (i_pri_start),
		.i_pri_stop  (i_pri_stop),
		.i_ext_cmd   (i_ext_cmd),
		.i_ext_start (i_ext_start),
		.i_ext_stop  (i_ext_stop),
		.i_zpd       (i_zpd),
		.i_stroke    (i_stroke),
		.i_acce_max  (i_acce_max),
		.i_deac_max  (i_deac_max),
		.o_drive     (o_drive),
		.o_dir       (o_dir),
		.o_ms        (o_ms),
		.o_status    (o_status)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	// count drive rises and log rt_speed once the table update has landed
	always @(negedge clk) begin
		if (o_drive && !drive_q) begin
			rises++;
			settle = 8;
		end else if (settle > 0) begin
			settle--;
			if (settle == 0) begin
				speed_log.push_back(int'(o_status.rt_speed));
			end
		end
		drive_q = o_drive;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end else begin
			return s >> 1;
		end
	endfunction

	// linear ramp floored at zero
	function automatic int ramp_at(input int addr);
		int v;
		v = motor_pkg::SPEED_TOP - motor_pkg::SPEED_SLOPE * addr;
		if (v < 0) begin
			v = 0;
		end
		return v;
	endfunction

	// slowest of both ramps and the command at each rise seen
	function automatic int expected_min_speed(input int speed, input int steps, input int done);
		int best;
		int a;
		int b;
		int s;
		best = 32'h7fffffff;
		for (int k = 1; k <= done; k++) begin
			a = ramp_at((k < acce_cap) ? k : acce_cap);
			b = ramp_at((steps - k < deac_cap) ? steps - k : deac_cap);
			s = (a > b) ? a : b;
			if (speed > s) begin
				s = speed;
			end
			if (s < best) begin
				best = s;
			end
		end
		return best;
	endfunction

	task automatic step_clk();
		@(posedge clk);
		#2;
	endtask

	task automatic draw_ms(output logic [motor_pkg::MS_W-1:0] code);
		for (int b = 0; b < motor_pkg::MS_W; b++) begin
			code[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic expect_eq(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0d ns: %s expected %0d, got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic set_row(input int idx, input bit sel, input bit use_ext, input bit dir,
			input int speed, input int steps, input int stroke, input int stop_at,
			input int zpd_at, input int exp_steps, input int exp_pos, input bit exp_zp,
			input bit exp_tp);
		rows[idx] = {sel, use_ext, dir, speed, steps, stroke, stop_at, zpd_at,
			exp_steps, exp_pos, exp_zp, exp_tp};
	endtask

	task automatic run_row(input int idx);
		move_t                          r;
		motor_pkg::motor_cmd_t          cmd;
		motor_pkg::motor_cmd_t          other;
		logic [motor_pkg::MS_W-1:0]     ms;
		int                             errs_before;
		int                             rise_base;
		int                             log_base;
		int                             waited;
		int                             got_rises;
		int                             min_seen;
		int                             mid_pos;
		bit                             started;
		r = rows[idx];
		errs_before = errors;
		draw_ms(ms);
		cmd.speed = r.speed[motor_pkg::SPEED_W-1:0];
		cmd.steps = r.steps[motor_pkg::STEP_W-1:0];
		cmd.dir = r.dir;
		cmd.ms = ms;
		// the idle port carries a different command
		other = cmd;
		other.dir = !r.dir;
		other.ms = ~ms;
		other.steps = cmd.steps + 1'b1;
		i_sel = r.sel;
		i_stroke = r.stroke[motor_pkg::STEP_W-1:0];
		i_ext_cmd = r.use_ext ? cmd : other;
		i_pri_cmd = r.use_ext ? other : cmd;
		rise_base = rises;
		log_base = speed_log.size();
		if (r.use_ext) begin
			i_ext_start = 1'b1;
		end else begin
			i_pri_start = 1'b1;
		end
		step_clk();
		i_ext_start = 1'b0;
		i_pri_start = 1'b0;
		waited = 0;
		while (!o_status.busy && waited < 4 * motor_pkg::TICK_DIV) begin
			step_clk();
			waited++;
		end
		started = o_status.busy;
		if (started != (r.exp_steps > 0)) begin
			$display("row %0d: axis start behaviour does not match the selected port", idx);
			errors++;
		end
		if (started && r.stop_at > 0) begin
			while (rises - rise_base < r.stop_at) begin
				step_clk();
			end
			i_pri_stop = !r.use_ext;
			i_ext_stop = r.use_ext;
			step_clk();
			i_pri_stop = 1'b0;
			i_ext_stop = 1'b0;
		end
		if (started && r.zpd_at > 0) begin
			while (rises - rise_base < r.zpd_at) begin
				step_clk();
			end
			// one fall fewer than rises while the drive is high
			mid_pos = r.dir ? pos_model - (r.zpd_at - 1) : pos_model + (r.zpd_at - 1);
			expect_eq("position before zero", int'(o_status.position), mid_pos);
			i_zpd = 1'b1;
		end
		while (o_status.busy) begin
			step_clk();
		end
		repeat (12) step_clk();
		i_zpd = 1'b0;
		step_clk();
		got_rises = rises - rise_base;
		expect_eq("steps", got_rises, r.exp_steps);
		expect_eq("position", int'(o_status.position), r.exp_pos);
		expect_eq("zpsign", int'(o_status.zpsign), int'(r.exp_zp));
		expect_eq("tpsign", int'(o_status.tpsign), int'(r.exp_tp));
		expect_eq("busy", int'(o_status.busy), 0);
		if (started) begin
			expect_eq("o_dir", int'(o_dir), int'(r.dir));
			expect_eq("o_ms", int'(o_ms), int'(ms));
		end
		if (got_rises > 0) begin
			min_seen = 32'h7fffffff;
			for (int i = log_base; i < speed_log.size(); i++) begin
				if (speed_log[i] < min_seen) begin
					min_seen = speed_log[i];
				end
			end
			if (min_seen < r.speed) begin
				$display("row %0d: rt_speed fell below the commanded speed", idx);
				errors++;
			end
			expect_eq("rt_speed min", min_seen,
				expected_min_speed(r.speed, r.steps, got_rises));
		end
		pos_model = r.exp_pos;
		if (errors == errs_before) begin
			$display("row %0d: passed, %0d steps", idx, got_rises);
			passed++;
		end else begin
			$display("row %0d: failed with %0d errors", idx, errors - errs_before);
			failed++;
		end
	endtask

	initial begin
		resetn = 1'b0;
		i_sel = 1'b0;
		i_pri_cmd = '0;
		i_pri_start = 1'b0;
		i_pri_stop = 1'b0;
		i_ext_cmd = '0;
		i_ext_start = 1'b0;
		i_ext_stop = 1'b0;
		i_zpd = 1'b0;
		i_stroke = '0;
		i_acce_max = acce_cap[motor_pkg::ADDR_W-1:0];
		i_deac_max = deac_cap[motor_pkg::ADDR_W-1:0];

		// sel ext dir speed steps stroke stop zpd | steps pos zp tp
		set_row(0, 1'b0, 1'b0, 1'b0, 6, 12, 1000, 0, 0, 12, 13, 1'b0, 1'b0);
		set_row(1, 1'b1, 1'b0, 1'b0, 6, 5, 1000, 0, 0, 0, 13, 1'b0, 1'b0);
		set_row(2, 1'b1, 1'b1, 1'b0, 8, 40, 1000, 0, 0, 40, 53, 1'b0, 1'b0);
		set_row(3, 1'b0, 1'b0, 1'b0, 25, 20, 1000, 3, 0, 3, 56, 1'b0, 1'b0);
		set_row(4, 1'b0, 1'b0, 1'b0, 10, 30, 64, 0, 0, 8, 64, 1'b0, 1'b1);
		set_row(5, 1'b1, 1'b1, 1'b1, 10, 30, 64, 0, 6, 6, 1, 1'b1, 1'b0);
		set_row(6, 1'b0, 1'b0, 1'b0, 34, 10, 64, 0, 0, 10, 11, 1'b0, 1'b0);

		for (int i = 0; i < $size(rows); i++) begin
			limit += rows[i].steps * (2 * motor_pkg::SPEED_TOP + 4) * motor_pkg::TICK_DIV;
		end
		limit += 4000;

		repeat (4) @(posedge clk);
		#2;
		resetn = 1'b1;
		repeat (2) step_clk();
		expect_eq("position after reset", int'(o_status.position), 1);

		for (int i = 0; i < $size(rows); i++) begin
			run_row(i);
		end

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			$size(rows), passed, failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
motor_pkg.sv
step_tick_gen.sv
speed_table.sv
motor_cmd_select.sv
step_motor_core.sv
position_tracker.sv
stepper_axis.sv
tb_stepper_axis.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_stepper_axis
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
